// ==== include/divsqrt_settings.svh ====
`ifndef DIVSQRT_SETTINGS_SVH
`define DIVSQRT_SETTINGS_SVH

// Operand and result width in bits
`define DIVSQRT_WIDTH 16

// Caller tag carried alongside each operation
`define DIVSQRT_TAG_WIDTH 4

// One root bit per iteration, two radicand bits consumed each time
`define DIVSQRT_SQRT_ITERS (`DIVSQRT_WIDTH / 2)

// Iteration counter width, must hold DIVSQRT_WIDTH
`define DIVSQRT_CNT_WIDTH 5

`endif

// ==== hdl/divsqrt_op_pkg.sv ====
`include "divsqrt_settings.svh"

package divsqrt_op_pkg;

  // ----------------------------
  // Operation select
  // ----------------------------
  // Integer divide or integer square root
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } op_e;

  // ----------------------------
  // Result status
  // ----------------------------
  // Only the divide-by-zero flag is reported
  typedef struct packed {
    logic div_by_zero;
  } status_t;

endpackage

// ==== hdl/divsqrt_pipe_pkg.sv ====
`include "divsqrt_settings.svh"

package divsqrt_pipe_pkg;

  // ----------------------------
  // Request payload
  // ----------------------------
  // Travels through the input stage into the control
  // 37 bits at the default widths
  typedef struct packed {
    logic [`DIVSQRT_WIDTH-1:0]     a;
    logic [`DIVSQRT_WIDTH-1:0]     b;
    divsqrt_op_pkg::op_e           op;
    logic [`DIVSQRT_TAG_WIDTH-1:0] tag;
  } req_t;

  // ----------------------------
  // Response payload
  // ----------------------------
  // Leaves the control through the output stage, 21 bits
  typedef struct packed {
    logic [`DIVSQRT_WIDTH-1:0]     result;
    divsqrt_op_pkg::status_t       status;
    logic [`DIVSQRT_TAG_WIDTH-1:0] tag;
  } rsp_t;

endpackage

// ==== hdl/divsqrt_pipe_stage.sv ====
`timescale 1ns/1ps
`include "divsqrt_settings.svh"

module divsqrt_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  // Upstream side
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  // Downstream side
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

  logic     valid_q;
  payload_t data_q;

  // Advance when downstream takes the item or the stage only holds a bubble
  assign in_ready_o = out_ready_i | ~valid_q;

  // Valid bit, synchronous clear on reset and flush
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // Payload only loads on an accepted item
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

// ==== hdl/divsqrt_iter_core.sv ====
`timescale 1ns/1ps
`include "divsqrt_settings.svh"

module divsqrt_iter_core (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      start_i,
  input  logic                      kill_i,
  input  divsqrt_op_pkg::op_e       op_i,
  input  logic [`DIVSQRT_WIDTH-1:0] a_i,
  input  logic [`DIVSQRT_WIDTH-1:0] b_i,
  output logic                      done_o,
  output logic [`DIVSQRT_WIDTH-1:0] result_o,
  output divsqrt_op_pkg::status_t   status_o
);

  // ----------------------------
  // State
  // ----------------------------
  logic                          busy_q;
  logic                          done_q;
  // Iterations still to run after the current one
  logic [`DIVSQRT_CNT_WIDTH-1:0] cnt_q;
  divsqrt_op_pkg::op_e           op_q;
  logic [`DIVSQRT_WIDTH-1:0]     divisor_q;
  // Dividend or radicand bits not yet consumed, MSB first
  logic [`DIVSQRT_WIDTH-1:0]     shift_q;
  logic [`DIVSQRT_WIDTH-1:0]     rem_q;
  // Quotient or root, built LSB-in
  logic [`DIVSQRT_WIDTH-1:0]     res_q;

  // Step inputs and outputs
  divsqrt_op_pkg::op_e           step_op;
  logic [`DIVSQRT_WIDTH-1:0]     step_div;
  logic [`DIVSQRT_WIDTH-1:0]     step_shift;
  logic [`DIVSQRT_WIDTH-1:0]     step_rem;
  logic [`DIVSQRT_WIDTH-1:0]     step_res;
  logic [`DIVSQRT_WIDTH+1:0]     partial;
  logic [`DIVSQRT_WIDTH+1:0]     trial;
  logic [`DIVSQRT_WIDTH+1:0]     diff;
  logic                          fits;
  logic                          step_en;
  logic [`DIVSQRT_WIDTH-1:0]     rem_next;
  logic [`DIVSQRT_WIDTH-1:0]     shift_next;

  // ----------------------------
  // One iteration
  // ----------------------------
  // First step runs on the start edge straight from the ports
  assign step_en = (start_i | busy_q) & ~kill_i;

  always_comb begin
    step_op    = start_i ? op_i : op_q;
    step_div   = start_i ? b_i : divisor_q;
    step_shift = start_i ? a_i : shift_q;
    step_rem   = start_i ? '0 : rem_q;
    step_res   = start_i ? '0 : res_q;
    if (step_op == divsqrt_op_pkg::OP_DIV) begin
      // Restoring division, bring in one dividend bit
      partial    = {1'b0, step_rem, step_shift[`DIVSQRT_WIDTH-1]};
      trial      = {2'b00, step_div};
      shift_next = {step_shift[`DIVSQRT_WIDTH-2:0], 1'b0};
    end else begin
      // Digit-by-digit root, bring in two radicand bits, trial is 4r+1
      partial    = {step_rem, step_shift[`DIVSQRT_WIDTH-1 -: 2]};
      trial      = {step_res, 2'b01};
      shift_next = {step_shift[`DIVSQRT_WIDTH-3:0], 2'b00};
    end
    fits     = (partial >= trial);
    diff     = partial - trial;
    // Remainder always fits back into WIDTH bits
    rem_next = fits ? diff[`DIVSQRT_WIDTH-1:0] : partial[`DIVSQRT_WIDTH-1:0];
  end

  // ----------------------------
  // Control
  // ----------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || kill_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      done_q <= 1'b0;
      cnt_q  <= (op_i == divsqrt_op_pkg::OP_DIV) ?
                `DIVSQRT_CNT_WIDTH'(`DIVSQRT_WIDTH - 1) :
                `DIVSQRT_CNT_WIDTH'(`DIVSQRT_SQRT_ITERS - 1);
    end else if (busy_q) begin
      cnt_q <= cnt_q - `DIVSQRT_CNT_WIDTH'(1);
      // Last step, done shows up next cycle
      if (cnt_q == `DIVSQRT_CNT_WIDTH'(1)) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end else begin
      done_q <= 1'b0;
    end
  end

  // Datapath registers
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q      <= op_i;
      divisor_q <= b_i;
    end
    if (step_en) begin
      shift_q <= shift_next;
      rem_q   <= rem_next;
      res_q   <= {step_res[`DIVSQRT_WIDTH-2:0], fits};
    end
  end

  assign done_o   = done_q;
  // Stable from done until the next start
  assign result_o = res_q;
  assign status_o.div_by_zero = (op_q == divsqrt_op_pkg::OP_DIV) && (divisor_q == '0);

endmodule

// ==== hdl/divsqrt_ctrl.sv ====
`timescale 1ns/1ps
`include "divsqrt_settings.svh"

module divsqrt_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      flush_i,
  // Requests from the input stage
  input  logic                      req_valid_i,
  input  divsqrt_pipe_pkg::req_t    req_data_i,
  output logic                      req_ready_o,
  // Core command
  output logic                      core_start_o,
  output divsqrt_op_pkg::op_e       core_op_o,
  output logic [`DIVSQRT_WIDTH-1:0] core_a_o,
  output logic [`DIVSQRT_WIDTH-1:0] core_b_o,
  // Core result
  input  logic                      core_done_i,
  input  logic [`DIVSQRT_WIDTH-1:0] core_result_i,
  input  divsqrt_op_pkg::status_t   core_status_i,
  // Responses to the output stage
  output logic                      rsp_valid_o,
  output divsqrt_pipe_pkg::rsp_t    rsp_data_o,
  input  logic                      rsp_ready_i,
  output logic                      busy_o
);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    HOLD
  } state_e;

  state_e                        state_q;
  state_e                        state_d;
  logic [`DIVSQRT_TAG_WIDTH-1:0] tag_q;

  // ----------------------------
  // Next state and handshakes
  // ----------------------------
  always_comb begin
    state_d     = state_q;
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    busy_o      = 1'b0;
    unique case (state_q)
      IDLE: begin
        // Free core, take the next request right away
        req_ready_o = 1'b1;
        if (req_valid_i) begin
          state_d = BUSY;
        end
      end
      BUSY: begin
        busy_o = 1'b1;
        if (core_done_i) begin
          rsp_valid_o = 1'b1;
          if (rsp_ready_i) begin
            // Result leaves now, back-to-back start possible
            req_ready_o = 1'b1;
            state_d     = req_valid_i ? BUSY : IDLE;
          end else begin
            state_d = HOLD;
          end
        end
      end
      HOLD: begin
        // Core keeps its result until the next start
        busy_o      = 1'b1;
        rsp_valid_o = 1'b1;
        if (rsp_ready_i) begin
          req_ready_o = 1'b1;
          state_d     = req_valid_i ? BUSY : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
    // Flush wins over everything
    if (flush_i) begin
      req_ready_o = 1'b0;
      rsp_valid_o = 1'b0;
      busy_o      = 1'b0;
      state_d     = IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------
  // Core start and tag
  // ----------------------------
  assign core_start_o = req_valid_i & req_ready_o;
  assign core_op_o    = req_data_i.op;
  assign core_a_o     = req_data_i.a;
  assign core_b_o     = req_data_i.b;

  // Tag follows the operation running in the core
  always_ff @(posedge clk_i) begin
    if (core_start_o) begin
      tag_q <= req_data_i.tag;
    end
  end

  assign rsp_data_o = '{result: core_result_i, status: core_status_i, tag: tag_q};

endmodule

// ==== hdl/divsqrt_top.sv ====
`timescale 1ns/1ps
`include "divsqrt_settings.svh"

module divsqrt_top (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Upstream
  input  logic                          in_valid_i,
  input  divsqrt_op_pkg::op_e           op_i,
  input  logic [`DIVSQRT_WIDTH-1:0]     operand_a_i,
  input  logic [`DIVSQRT_WIDTH-1:0]     operand_b_i,
  input  logic [`DIVSQRT_TAG_WIDTH-1:0] tag_i,
  output logic                          in_ready_o,
  // Downstream
  output logic                          out_valid_o,
  output logic [`DIVSQRT_WIDTH-1:0]     result_o,
  output divsqrt_op_pkg::status_t       status_o,
  output logic [`DIVSQRT_TAG_WIDTH-1:0] tag_o,
  input  logic                          out_ready_i,
  // Global
  input  logic                          flush_i,
  output logic                          busy_o
);

  divsqrt_pipe_pkg::req_t        in_req;
  divsqrt_pipe_pkg::req_t        req_data;
  logic                          req_valid;
  logic                          req_ready;
  logic                          core_start;
  divsqrt_op_pkg::op_e           core_op;
  logic [`DIVSQRT_WIDTH-1:0]     core_a;
  logic [`DIVSQRT_WIDTH-1:0]     core_b;
  logic                          core_done;
  logic [`DIVSQRT_WIDTH-1:0]     core_result;
  divsqrt_op_pkg::status_t       core_status;
  logic                          rsp_valid;
  logic                          rsp_ready;
  divsqrt_pipe_pkg::rsp_t        rsp_data;
  divsqrt_pipe_pkg::rsp_t        out_rsp;
  logic                          ctrl_busy;

  // Pack loose request ports
  assign in_req = '{a: operand_a_i, b: operand_b_i, op: op_i, tag: tag_i};

  // ----------------------------
  // Input stage
  // ----------------------------
  divsqrt_pipe_stage #(
    .payload_t (divsqrt_pipe_pkg::req_t)
  ) u_in_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_data_i   (in_req),
    .in_ready_o  (in_ready_o),
    .out_valid_o (req_valid),
    .out_data_o  (req_data),
    .out_ready_i (req_ready)
  );

  // ----------------------------
  // Control and core
  // ----------------------------
  divsqrt_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .req_valid_i   (req_valid),
    .req_data_i    (req_data),
    .req_ready_o   (req_ready),
    .core_start_o  (core_start),
    .core_op_o     (core_op),
    .core_a_o      (core_a),
    .core_b_o      (core_b),
    .core_done_i   (core_done),
    .core_result_i (core_result),
    .core_status_i (core_status),
    .rsp_valid_o   (rsp_valid),
    .rsp_data_o    (rsp_data),
    .rsp_ready_i   (rsp_ready),
    .busy_o        (ctrl_busy)
  );

  // Flush kills the running iteration
  divsqrt_iter_core u_core (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .start_i  (core_start),
    .kill_i   (flush_i),
    .op_i     (core_op),
    .a_i      (core_a),
    .b_i      (core_b),
    .done_o   (core_done),
    .result_o (core_result),
    .status_o (core_status)
  );

  // ----------------------------
  // Output stage
  // ----------------------------
  divsqrt_pipe_stage #(
    .payload_t (divsqrt_pipe_pkg::rsp_t)
  ) u_out_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (rsp_valid),
    .in_data_i   (rsp_data),
    .in_ready_o  (rsp_ready),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_rsp),
    .out_ready_i (out_ready_i)
  );

  // Unpack response onto loose ports
  assign result_o = out_rsp.result;
  assign status_o = out_rsp.status;
  assign tag_o    = out_rsp.tag;

  // Anything held in either stage or the core counts as in flight
  assign busy_o = req_valid | ctrl_busy | out_valid_o;

endmodule

// ==== verif/divsqrt_checker.sv ====
`timescale 1ns/1ps
`include "divsqrt_settings.svh"

module divsqrt_checker (
  input logic                          clk_i,
  input logic                          rst_n_i,
  input logic                          flush_i,
  input logic                          out_valid_i,
  input logic                          out_ready_i,
  input logic [`DIVSQRT_WIDTH-1:0]     result_i,
  input divsqrt_op_pkg::status_t       status_i,
  input logic [`DIVSQRT_TAG_WIDTH-1:0] out_tag_i,
  input logic                          busy_i
);

  // Failed assertions so far, read by the testbench at the end
  int err_count = 0;

  // ------------------------------
  // Output handshake
  // ------------------------------
  // Stalled response keeps valid and payload until taken
  out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i && !flush_i |=>
      out_valid_i && $stable(result_i) && $stable(status_i) && $stable(out_tag_i))
    else begin
      $error("Stalled response changed or dropped before it was taken");
      err_count = err_count + 1;
    end

  // ------------------------------
  // Flush and busy
  // ------------------------------
  // Nothing left in flight one cycle after a flush
  flush_clears: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !out_valid_i && !busy_i)
    else begin
      $error("Response or busy still high in the cycle after flush");
      err_count = err_count + 1;
    end

  // A response only shows up after an operation was in flight
  valid_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(out_valid_i) |-> $past(busy_i))
    else begin
      $error("Response became valid while nothing was in flight");
      err_count = err_count + 1;
    end

endmodule

bind divsqrt_top divsqrt_checker u_checker (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .flush_i     (flush_i),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .result_i    (result_o),
  .status_i    (status_o),
  .out_tag_i   (tag_o),
  .busy_i      (busy_o)
);

// ==== verif/divsqrt_tb.sv ====
`timescale 1ns/1ps
`include "divsqrt_settings.svh"

module divsqrt_tb;

  localparam int W       = `DIVSQRT_WIDTH;
  localparam int TIMEOUT = 200;

  typedef logic [W-1:0]                  word_t;
  typedef logic [`DIVSQRT_TAG_WIDTH-1:0] tag_t;

  logic                    clk;
  logic                    rst_n;
  logic                    in_valid;
  logic                    in_ready;
  divsqrt_op_pkg::op_e     op_sel;
  word_t                   opa;
  word_t                   opb;
  tag_t                    tag_in;
  logic                    out_valid;
  logic                    out_ready;
  word_t                   result;
  divsqrt_op_pkg::status_t status;
  tag_t                    tag_out;
  logic                    flush;
  logic                    busy;

  integer seed;
  int     err_cnt;
  int     pass_cnt;
  int     fail_cnt;

  divsqrt_top divsqrt_top_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .in_valid_i  (in_valid),
    .op_i        (op_sel),
    .operand_a_i (opa),
    .operand_b_i (opb),
    .tag_i       (tag_in),
    .in_ready_o  (in_ready),
    .out_valid_o (out_valid),
    .result_o    (result),
    .status_o    (status),
    .tag_o       (tag_out),
    .out_ready_i (out_ready),
    .flush_i     (flush),
    .busy_o      (busy)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  // ------------------------------
  // Reference model
  // ------------------------------
  // Divide by zero gives all ones
  function automatic word_t div_model(input word_t a, input word_t b);
    if (b == '0) begin
      return '1;
    end
    return a / b;
  endfunction

  // Largest r with r*r not above a
  function automatic word_t sqrt_model(input word_t a);
    logic [2*W-1:0] r;
    r = '0;
    while ((r + 1) * (r + 1) <= {{W{1'b0}}, a}) begin
      r = r + 1;
    end
    return r[W-1:0];
  endfunction

  // ------------------------------
  // Bus tasks
  // ------------------------------
  // Entered and left 1 ns after a rising edge
  task automatic send_req(input string name, input divsqrt_op_pkg::op_e op,
                          input word_t a, input word_t b, input tag_t tag);
    int   cycles;
    logic ok;
    cycles   = 0;
    ok       = 1'b0;
    in_valid = 1'b1;
    op_sel   = op;
    opa      = a;
    opb      = b;
    tag_in   = tag;
    while (!ok && cycles < TIMEOUT) begin
      // Ready is sampled mid-cycle and the next edge is the transfer
      @(negedge clk);
      ok = in_ready;
      @(posedge clk);
      #1;
      cycles++;
    end
    in_valid = 1'b0;
    assert (ok) else begin
      $display("%s: request was not accepted within %0d cycles", name, TIMEOUT);
      err_cnt++;
    end
  endtask

  task automatic recv_rsp(input string name, output word_t res,
                          output divsqrt_op_pkg::status_t st, output tag_t tg);
    int   cycles;
    logic got;
    cycles = 0;
    got    = 1'b0;
    res    = '0;
    st     = '0;
    tg     = '0;
    while (!got && cycles < TIMEOUT) begin
      @(negedge clk);
      if (out_valid && out_ready) begin
        got = 1'b1;
        res = result;
        st  = status;
        tg  = tag_out;
      end
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (got) else begin
      $display("%s: no response arrived within %0d cycles", name, TIMEOUT);
      err_cnt++;
    end
  endtask

  // Expected values come from the model above
  task automatic check_rsp(input string name, input divsqrt_op_pkg::op_e op,
                           input word_t a, input word_t b, input tag_t tag,
                           input word_t res, input divsqrt_op_pkg::status_t st,
                           input tag_t tg);
    word_t exp_res;
    logic  exp_dbz;
    exp_res = (op == divsqrt_op_pkg::OP_DIV) ? div_model(a, b) : sqrt_model(a);
    exp_dbz = (op == divsqrt_op_pkg::OP_DIV) && (b == '0);
    assert (res == exp_res) else begin
      $display("Error %s: result expected %h actual %h", name, exp_res, res);
      err_cnt++;
    end
    assert (st.div_by_zero == exp_dbz) else begin
      $display("Error %s: div_by_zero expected %b actual %b", name, exp_dbz, st.div_by_zero);
      err_cnt++;
    end
    assert (tg == tag) else begin
      $display("Error %s: tag expected %h actual %h", name, tag, tg);
      err_cnt++;
    end
  endtask

  task automatic run_op(input string name, input divsqrt_op_pkg::op_e op,
                        input word_t a, input word_t b, input tag_t tag);
    word_t                   res;
    divsqrt_op_pkg::status_t st;
    tag_t                    tg;
    send_req(name, op, a, b, tag);
    recv_rsp(name, res, st, tg);
    check_rsp(name, op, a, b, tag, res, st, tg);
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("%s: finished, no errors", name);
    end else begin
      fail_cnt++;
      $display("%s: finished, %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic test_reset();
    int e0;
    e0 = err_cnt;
    assert (in_ready == 1'b1) else begin
      $display("Error reset: in_ready expected 1 actual %b", in_ready);
      err_cnt++;
    end
    assert (out_valid == 1'b0) else begin
      $display("Error reset: out_valid expected 0 actual %b", out_valid);
      err_cnt++;
    end
    assert (busy == 1'b0) else begin
      $display("Error reset: busy expected 0 actual %b", busy);
      err_cnt++;
    end
    end_test("reset", e0);
  endtask

  task automatic test_div();
    int          e0;
    logic [31:0] rnd;
    word_t       b;
    e0 = err_cnt;
    for (int i = 0; i < 20; i++) begin
      rnd = $random(seed);
      // Shift spreads divisor sizes so quotients are not mostly zero
      b = rnd[31:16] >> rnd[3:0];
      if (b == '0) begin
        b = word_t'(1);
      end
      run_op("div", divsqrt_op_pkg::OP_DIV, rnd[W-1:0], b, tag_t'(i));
    end
    end_test("div", e0);
  endtask

  task automatic test_sqrt();
    int          e0;
    logic [31:0] rnd;
    e0 = err_cnt;
    // Both ends of the range first
    run_op("sqrt", divsqrt_op_pkg::OP_SQRT, '0, '0, tag_t'(0));
    run_op("sqrt", divsqrt_op_pkg::OP_SQRT, '1, '0, tag_t'(1));
    for (int i = 0; i < 20; i++) begin
      rnd = $random(seed);
      run_op("sqrt", divsqrt_op_pkg::OP_SQRT, rnd[W-1:0], '0, tag_t'(i));
    end
    end_test("sqrt", e0);
  endtask

  task automatic test_div_zero();
    int          e0;
    logic [31:0] rnd;
    e0  = err_cnt;
    rnd = $random(seed);
    run_op("div_zero", divsqrt_op_pkg::OP_DIV, '0, '0, tag_t'(3));
    run_op("div_zero", divsqrt_op_pkg::OP_DIV, word_t'(1234), '0, tag_t'(4));
    run_op("div_zero", divsqrt_op_pkg::OP_DIV, rnd[W-1:0], '0, tag_t'(5));
    end_test("div_zero", e0);
  endtask

  task automatic test_backpressure();
    int                      e0;
    logic                    seen;
    word_t                   res;
    divsqrt_op_pkg::status_t st;
    tag_t                    tg;
    word_t                   a_arr [3] = '{16'd50000, 16'd40000, 16'd777};
    word_t                   b_arr [3] = '{16'd7, 16'd0, 16'd3};
    divsqrt_op_pkg::op_e     ops [3] = '{divsqrt_op_pkg::OP_DIV, divsqrt_op_pkg::OP_SQRT,
                                         divsqrt_op_pkg::OP_DIV};
    e0        = err_cnt;
    seen      = 1'b0;
    out_ready = 1'b0;
    // Fills input stage, core and output stage
    for (int i = 0; i < 3; i++) begin
      send_req("backpressure", ops[i], a_arr[i], b_arr[i], tag_t'(i + 5));
    end
    for (int c = 0; c < 60; c++) begin
      @(negedge clk);
      assert (!(seen && !out_valid)) else begin
        $display("backpressure: out_valid dropped while out_ready was low");
        err_cnt++;
      end
      seen = seen | out_valid;
      @(posedge clk);
      #1;
    end
    assert (seen) else begin
      $display("backpressure: no response became valid while the output was stalled");
      err_cnt++;
    end
    out_ready = 1'b1;
    // Request order expected
    for (int i = 0; i < 3; i++) begin
      recv_rsp("backpressure", res, st, tg);
      check_rsp("backpressure", ops[i], a_arr[i], b_arr[i], tag_t'(i + 5), res, st, tg);
    end
    end_test("backpressure", e0);
  endtask

  task automatic test_flush();
    int e0;
    e0 = err_cnt;
    send_req("flush", divsqrt_op_pkg::OP_DIV, word_t'(60000), word_t'(3), tag_t'(9));
    // Let the operation reach the core
    repeat (4) @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    assert (busy == 1'b0) else begin
      $display("Error flush: busy expected 0 actual %b", busy);
      err_cnt++;
    end
    assert (out_valid == 1'b0) else begin
      $display("Error flush: out_valid expected 0 actual %b", out_valid);
      err_cnt++;
    end
    // Longer than a full division
    for (int c = 0; c < 40; c++) begin
      @(negedge clk);
      assert (!out_valid) else begin
        $display("flush: a response appeared for the flushed request");
        err_cnt++;
      end
      @(posedge clk);
      #1;
    end
    run_op("flush", divsqrt_op_pkg::OP_DIV, word_t'(1000), word_t'(7), tag_t'(10));
    end_test("flush", e0);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    seed      = 1207;
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    op_sel    = divsqrt_op_pkg::OP_DIV;
    opa       = '0;
    opb       = '0;
    tag_in    = '0;
    out_ready = 1'b1;
    flush     = 1'b0;
    err_cnt   = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    test_div();
    test_sqrt();
    test_div_zero();
    test_backpressure();
    test_flush();
    $display("Summary: %0d tests passed, %0d tests failed, %0d errors, %0d assertion failures",
             pass_cnt, fail_cnt, err_cnt, divsqrt_top_i.u_checker.err_count);
    if (err_cnt == 0 && divsqrt_top_i.u_checker.err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+include
hdl/divsqrt_op_pkg.sv
hdl/divsqrt_pipe_pkg.sv
hdl/divsqrt_pipe_stage.sv
hdl/divsqrt_iter_core.sv
hdl/divsqrt_ctrl.sv
hdl/divsqrt_top.sv
verif/divsqrt_checker.sv
verif/divsqrt_tb.sv

// ==== Makefile ====
# Verilator flow for the divide and square-root testbench

SIM = obj_dir/divsqrt_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f files.f --top-module divsqrt_tb -Mdir obj_dir -o divsqrt_sim

# Pass only if the log holds the pass line
run: compile
	./$(SIM) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
